//--- src.f
rtl/bank_mem_pkg.sv
rtl/bank_port_if.sv
rtl/reset_stretch.sv
rtl/bank_decoder.sv
rtl/mem_bank.sv
rtl/read_return.sv
rtl/bank_memory_top.sv
sim/tb_bank_memory.sv

//--- sim/tb_bank_memory.sv
`timescale 1ns/100ps

module tb_bank_memory
    import bank_mem_pkg::*;
();

    localparam int unsigned ADDR_SPACE = 2 ** ADDR_W;
    localparam int unsigned WAIT_LIMIT = 64;

    // one row of the operation table
    typedef struct {
        logic  is_write;
        addr_t addr;
        strb_t be;
        data_t wdata;
        data_t exp;
    } op_t;

    logic  clk;
    logic  reset;
    logic  req;
    addr_t addr;
    logic  we;
    strb_t be;
    data_t wdata;
    logic  ready;
    logic  rvalid;
    data_t rdata;

    op_t   ops [$];
    data_t model [ADDR_SPACE];
    bit    written [ADDR_SPACE];
    addr_t wr_list [$];

    // expected word and due cycle of each outstanding read
    data_t rd_exp [$];
    int    rd_due [$];

    int cycle;

    bank_memory_top DUT (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .addr   (addr),
        .we     (we),
        .be     (be),
        .wdata  (wdata),
        .ready  (ready),
        .rvalid (rvalid),
        .rdata  (rdata)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // edges seen so far
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_failed();
        $display("Regression failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            stop_failed();
        end
    endtask

    // enabled bytes come from the new word
    function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                          input strb_t lanes);
        data_t result;
        result = old_word;
        for (int b = 0; b < STRB_W; b++) begin
            if (lanes[b]) begin
                result[b*BYTE_W +: BYTE_W] = new_word[b*BYTE_W +: BYTE_W];
            end
        end
        return result;
    endfunction

    function automatic addr_t make_addr(input int bank, input int word);
        return {bank_idx_t'(bank), offset_t'(word)};
    endfunction

    // pattern that depends on every address bit
    function automatic data_t addr_pattern(input addr_t a);
        return {6'h2b, a, 6'h15, ~a};
    endfunction

    task automatic add_write(input addr_t a, input strb_t lanes, input data_t d);
        op_t e;
        e.is_write = 1'b1;
        e.addr     = a;
        e.be       = lanes;
        e.wdata    = d;
        model[a]   = merge_bytes(model[a], d, lanes);
        e.exp      = model[a];
        if (!written[a]) begin
            written[a] = 1'b1;
            wr_list.push_back(a);
        end
        ops.push_back(e);
    endtask

    task automatic add_read(input addr_t a);
        op_t e;
        e.is_write = 1'b0;
        e.addr     = a;
        e.be       = '0;
        e.wdata    = '0;
        e.exp      = model[a];
        ops.push_back(e);
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (ready !== 1'b1) begin
            if (n == WAIT_LIMIT) begin
                $display("timed out at %0t waiting for ready to rise", $time);
                stop_failed();
            end
            @(negedge clk);
            n++;
        end
    endtask

    task automatic drain_reads();
        int n;
        n = 0;
        while (rd_exp.size() != 0) begin
            if (n == WAIT_LIMIT) begin
                $display("timed out at %0t with %0d reads still waiting for rvalid",
                         $time, rd_exp.size());
                stop_failed();
            end
            @(negedge clk);
            n++;
        end
    endtask

    // issue the whole table back to back with one request per cycle
    task automatic apply_ops();
        op_t e;
        wait_ready();
        while (ops.size() != 0) begin
            e = ops.pop_front();
            @(posedge clk);
            req   <= 1'b1;
            addr  <= e.addr;
            we    <= e.is_write;
            be    <= e.be;
            wdata <= e.wdata;
            if (!e.is_write) begin
                rd_exp.push_back(e.exp);
                // accepted on the next edge and returned one edge later
                rd_due.push_back(cycle + 2);
            end
        end
        @(posedge clk);
        req <= 1'b0;
        we  <= 1'b0;
        drain_reads();
    endtask

    // write while ready is low that must not reach memory
    task automatic drop_write(input addr_t a, input data_t d);
        @(negedge clk);
        check_value("ready", ready, 1'b0);
        @(posedge clk);
        req   <= 1'b1;
        addr  <= a;
        we    <= 1'b1;
        be    <= '1;
        wdata <= d;
        @(posedge clk);
        req <= 1'b0;
        we  <= 1'b0;
    endtask

    // read return monitor
    always @(negedge clk) begin : read_monitor
        int    due;
        data_t exp;
        if (rvalid === 1'b1) begin
            if (rd_exp.size() == 0) begin
                $display("rvalid rose at %0t with no read outstanding", $time);
                stop_failed();
            end else begin
                due = rd_due.pop_front();
                exp = rd_exp.pop_front();
                check_value("rvalid cycle", cycle, due);
                check_value("rdata", rdata, exp);
            end
        end else if (rd_due.size() != 0 && cycle >= rd_due[0]) begin
            $display("rvalid missing at %0t for a read due in cycle %0d", $time, rd_due[0]);
            stop_failed();
        end
    end

    initial begin
        addr_t a;
        strb_t lanes;
        reset  = 1'b1;
        req    = 1'b0;
        addr   = '0;
        we     = 1'b0;
        be     = '0;
        wdata  = '0;
        cycle  = 0;
        void'($urandom(32'h18920ed9));

        // ready rises on the 16th edge after release
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        for (int i = 1; i <= RESET_HOLD; i++) begin
            @(posedge clk);
            @(negedge clk);
            check_value("ready", ready, (i == RESET_HOLD));
            check_value("rvalid", rvalid, 1'b0);
        end

        // full words in every bank
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_write(make_addr(b, 0), '1, addr_pattern(make_addr(b, 0)));
            add_write(make_addr(b, 1), '1, addr_pattern(make_addr(b, 1)));
            add_write(make_addr(b, BANK_WORDS - 1), '1,
                      addr_pattern(make_addr(b, BANK_WORDS - 1)));
        end
        for (int b = 0; b < NUM_BANKS; b++) begin
            add_read(make_addr(b, 0));
            add_read(make_addr(b, 1));
            add_read(make_addr(b, BANK_WORDS - 1));
        end
        apply_ops();

        // partial byte enables
        a = make_addr(2, 37);
        add_write(a, 4'b1111, 32'h1122_3344);
        add_write(a, 4'b0001, 32'haabb_ccdd);
        add_read(a);
        add_write(a, 4'b1010, 32'h5566_7788);
        add_read(a);
        add_write(a, 4'b0000, 32'hffff_ffff);
        add_read(a);
        add_write(make_addr(1, 90), 4'b1111, 32'h0f0f_0f0f);
        add_write(make_addr(1, 90), 4'b0110, 32'hf0f0_f0f0);
        add_read(make_addr(1, 90));
        apply_ops();

        // back-to-back reads hopping between banks
        add_read(make_addr(0, 0));
        add_read(make_addr(2, 1));
        add_read(make_addr(1, 0));
        add_read(make_addr(3, BANK_WORDS - 1));
        add_read(make_addr(2, 37));
        add_read(make_addr(0, 1));
        add_read(make_addr(3, 0));
        add_read(make_addr(1, 90));
        // read right behind a write to the same word
        add_write(make_addr(3, 0), '1, 32'hdead_beef);
        add_read(make_addr(3, 0));
        add_write(make_addr(0, 1), 4'b1100, 32'h1234_5678);
        add_read(make_addr(0, 1));
        add_read(make_addr(1, 1));
        apply_ops();

        // reset in the middle of a run keeps the contents
        a = make_addr(1, 200);
        add_write(a, '1, 32'hcafe_f00d);
        apply_ops();
        @(posedge clk);
        reset <= 1'b1;
        @(posedge clk);
        drop_write(a, 32'h0bad_0bad);
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        drop_write(a, 32'h0bad_1bad);
        add_read(a);
        add_read(make_addr(2, 37));
        add_read(make_addr(3, 0));
        apply_ops();

        // random entries against the model
        for (int i = 0; i < 48; i++) begin
            if (wr_list.size() == 0 || $urandom_range(1, 0) == 1) begin
                a = addr_t'($urandom);
                if (written[a]) begin
                    lanes = strb_t'($urandom_range(15, 1));
                end else begin
                    lanes = '1;
                end
                add_write(a, lanes, $urandom);
            end else begin
                add_read(wr_list[$urandom_range(wr_list.size() - 1, 0)]);
            end
        end
        apply_ops();

        $display("Regression passed");
        $finish;
    end

endmodule

//--- rtl/bank_memory_top.sv
`timescale 1ns/100ps

module bank_memory_top
    import bank_mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,

    // request side
    input  logic  req,
    input  addr_t addr,
    input  logic  we,
    input  strb_t be,
    input  data_t wdata,

    // status and read return
    output logic  ready,
    output logic  rvalid,
    output data_t rdata
);

    logic      core_reset;
    logic      rd_issue;
    bank_idx_t rd_bank;

    bank_port_if banks [NUM_BANKS] ();

    // stretched reset for the core logic
    reset_stretch u_reset_stretch (
        .clk        (clk),
        .reset      (reset),
        .core_reset (core_reset),
        .ready      (ready)
    );

    bank_decoder u_bank_decoder (
        .ready    (ready),
        .req      (req),
        .addr     (addr),
        .we       (we),
        .be       (be),
        .wdata    (wdata),

        .banks    (banks),

        .rd_issue (rd_issue),
        .rd_bank  (rd_bank)
    );

    // identical banks
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_mem
        mem_bank u_mem_bank (
            .clk  (clk),
            .port (banks[i])
        );
    end

    read_return u_read_return (
        .clk        (clk),
        .core_reset (core_reset),

        .banks      (banks),

        .rd_issue   (rd_issue),
        .rd_bank    (rd_bank),

        .rvalid     (rvalid),
        .rdata      (rdata)
    );

endmodule

//--- rtl/read_return.sv
`timescale 1ns/100ps

module read_return
    import bank_mem_pkg::*;
(
    input  logic      clk,
    input  logic      core_reset,

    bank_port_if.host banks [NUM_BANKS],

    input  logic      rd_issue,
    input  bank_idx_t rd_bank,

    output logic      rvalid,
    output data_t     rdata
);

    data_t     bank_rdata [NUM_BANKS];
    bank_idx_t rd_bank_q;

    // gather the banks' read words into a plain array for the mux
    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_collect
        assign bank_rdata[i] = banks[i].rdata;
    end

    // valid lines up with the banks' registered outputs
    always_ff @(posedge clk) begin
        if (core_reset) begin
            rvalid <= 1'b0;
        end else begin
            rvalid <= rd_issue;
        end
    end

    // keep the last read's bank so rdata stays put between reads
    always_ff @(posedge clk) begin
        if (rd_issue) begin
            rd_bank_q <= rd_bank;
        end
    end

    assign rdata = bank_rdata[rd_bank_q];

endmodule

//--- rtl/mem_bank.sv
`timescale 1ns/100ps

module mem_bank
    import bank_mem_pkg::*;
(
    input  logic     clk,
    bank_port_if.bank port
);

    data_t mem [BANK_WORDS];
    data_t rdata_q;

    logic wr_en;
    logic rd_en;

    assign wr_en = port.req && port.we;
    assign rd_en = port.req && !port.we;

    // byte-lane write, only enabled lanes change
    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (port.be[b]) begin
                    mem[port.offset][b*BYTE_W +: BYTE_W] <= port.wdata[b*BYTE_W +: BYTE_W];
                end
            end
        end
    end

    // registered read, holds between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_q <= mem[port.offset];
        end
    end

    assign port.rdata = rdata_q;

endmodule

//--- rtl/bank_decoder.sv
`timescale 1ns/100ps

module bank_decoder
    import bank_mem_pkg::*;
(
    input  logic        ready,
    input  logic        req,
    input  addr_t       addr,
    input  logic        we,
    input  strb_t       be,
    input  data_t       wdata,

    bank_port_if.host   banks [NUM_BANKS],

    output logic        rd_issue,
    output bank_idx_t   rd_bank
);

    logic      accept;
    bank_idx_t bank_sel;
    offset_t   offset;

    // requests while not ready are simply lost
    assign accept = req && ready;

    // top bits pick the bank, low bits the word
    assign bank_sel = addr[ADDR_W-1 -: BANK_W];
    assign offset   = addr[OFFSET_W-1:0];

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        // strobe only the addressed bank
        assign banks[i].req = accept && (bank_sel == bank_idx_t'(i));

        // payload is broadcast to every bank
        assign banks[i].we     = we;
        assign banks[i].be     = be;
        assign banks[i].offset = offset;
        assign banks[i].wdata  = wdata;
    end

    // tell the return stage a read is in flight and where it went
    assign rd_issue = accept && !we;
    assign rd_bank  = bank_sel;

endmodule

//--- rtl/reset_stretch.sv
`timescale 1ns/100ps

module reset_stretch
    import bank_mem_pkg::*;
(
    input  logic clk,
    input  logic reset,
    output logic core_reset,
    output logic ready
);

    hold_state_t state;
    hold_cnt_t   count;

    // count edges with reset low, release on the last one
    always_ff @(posedge clk) begin
        if (reset) begin
            state <= HOLD;
            count <= '0;
        end else begin
            case (state)
                HOLD: begin
                    if (count == hold_cnt_t'(RESET_HOLD - 1)) begin
                        state <= RUN;
                    end else begin
                        count <= count + 1'b1;
                    end
                end
                default: begin
                    state <= RUN;
                end
            endcase
        end
    end

    // both follow the state register directly
    assign core_reset = (state == HOLD);
    assign ready      = (state == RUN);

endmodule

//--- rtl/bank_port_if.sv
`timescale 1ns/100ps

interface bank_port_if
    import bank_mem_pkg::*;
();

    // one-cycle request strobe, already gated and steered
    logic    req;
    logic    we;
    strb_t   be;
    offset_t offset;
    data_t   wdata;

    // registered read word from the bank
    data_t   rdata;

    // decoder and return stage side
    modport host (
        output req,
        output we,
        output be,
        output offset,
        output wdata,
        input  rdata
    );

    // memory bank side
    modport bank (
        input  req,
        input  we,
        input  be,
        input  offset,
        input  wdata,
        output rdata
    );

endinterface

//--- rtl/bank_mem_pkg.sv
package bank_mem_pkg;

    // bank geometry
    localparam int unsigned NUM_BANKS  = 4;
    localparam int unsigned BANK_WORDS = 256;

    // data word and byte lanes
    localparam int unsigned DATA_W = 32;
    localparam int unsigned BYTE_W = 8;
    localparam int unsigned STRB_W = DATA_W / BYTE_W;

    // address split, bank index sits above the word offset
    localparam int unsigned BANK_W   = $clog2(NUM_BANKS);
    localparam int unsigned OFFSET_W = $clog2(BANK_WORDS);
    localparam int unsigned ADDR_W   = BANK_W + OFFSET_W;

    // cycles the core stays in reset once the reset input drops
    localparam int unsigned RESET_HOLD = 16;
    localparam int unsigned HOLD_CNT_W = $clog2(RESET_HOLD);

    // one data word
    typedef logic [DATA_W-1:0] data_t;

    // one enable bit per byte of data_t
    typedef logic [STRB_W-1:0] strb_t;

    // bank number
    typedef logic [BANK_W-1:0] bank_idx_t;

    // word offset inside a bank
    typedef logic [OFFSET_W-1:0] offset_t;

    // full word address
    typedef logic [ADDR_W-1:0] addr_t;

    // reset hold counter
    typedef logic [HOLD_CNT_W-1:0] hold_cnt_t;

    // reset stretcher states
    typedef enum logic {
        HOLD,
        RUN
    } hold_state_t;

endpackage
